// ==== hw/sa_acc.sv ====
`timescale 1ns/1ps
`include "sa_settings.svh"

module sa_acc (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  sa_pkg::psum_row_s               psum_row_i,  // Row from the array
    input  sa_pkg::col_vec_t                rden_i,      // Host pop strobe
    output sa_pkg::psum_t [`SA_PE_SIZE-1:0] head_o,      // FIFO heads
    output sa_pkg::col_vec_t                full_o,
    output sa_pkg::col_vec_t                empty_o
);

    localparam int N = `SA_PE_SIZE;

    sa_pkg::psum_t [N-1:0] feedback;     // Head when full, else zero
    sa_pkg::psum_t [N-1:0] fifo_in;
    sa_pkg::col_vec_t      fifo_rd;

    for (genvar j = 0; j < N; j++) begin : g_col
        // Preload until full, then fold into the oldest entry
        assign feedback[j] = full_o[j] ? head_o[j] : '0;
        assign fifo_in[j]  = feedback[j] + psum_row_i.psum[j];

        // Pop on accumulate or host read
        assign fifo_rd[j]  = (psum_row_i.valid && full_o[j]) || rden_i[j];

        sa_acc_fifo #(
            .DEPTH (`SA_FIFO_DEPTH),
            .WIDTH ($bits(sa_pkg::psum_t))
        ) u_fifo (
            .clk     (clk),
            .rst_n_i (rst_n_i),
            .wren_i  (psum_row_i.valid),    // Every valid row writes
            .rden_i  (fifo_rd[j]),
            .wdata_i (fifo_in[j]),
            .rdata_o (head_o[j]),
            .full_o  (full_o[j]),
            .empty_o (empty_o[j])
        );
    end

endmodule

// ==== hw/sa_acc_fifo.sv ====
`timescale 1ns/1ps
`include "sa_settings.svh"

module sa_acc_fifo #(
    parameter int DEPTH = `SA_FIFO_DEPTH,
    parameter int WIDTH = `SA_PSUM_W
) (
    input  logic             clk,
    input  logic             rst_n_i,
    input  logic             wren_i,
    input  logic             rden_i,
    input  logic [WIDTH-1:0] wdata_i,
    output logic [WIDTH-1:0] rdata_o,     // Head, combinational
    output logic             full_o,
    output logic             empty_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_wr;
    logic             do_rd;

    // Wrap at DEPTH, not only powers of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full_o  = count_q == CNT_W'(DEPTH);
    assign empty_o = count_q == '0;
    assign do_rd   = rden_i && !empty_o;
    assign do_wr   = wren_i && (!full_o || do_rd);  // Write at full only with a pop
    assign rdata_o = mem[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_wr) wr_ptr_q <= ptr_next(wr_ptr_q);
            if (do_rd) rd_ptr_q <= ptr_next(rd_ptr_q);
            if (do_wr && !do_rd) begin
                count_q <= count_q + 1'b1;
            end else if (do_rd && !do_wr) begin
                count_q <= count_q - 1'b1;
            end                                     // Both at once, count holds
        end
    end

    // At full the write slot is the popped head
    always_ff @(posedge clk) begin
        if (do_wr) mem[wr_ptr_q] <= wdata_i;
    end

endmodule

// ==== hw/sa_array.sv ====
`timescale 1ns/1ps
`include "sa_settings.svh"

module sa_array (
    input  logic              clk,
    input  logic              rst_n_i,
    input  sa_pkg::act_row_s  act_row_i,
    input  sa_pkg::wt_wr_s    wt_wr_i,
    output sa_pkg::psum_row_s psum_row_o
);

    localparam int N   = `SA_PE_SIZE;
    localparam int LAT = `SA_LATENCY;

    sa_pkg::act_t          act_in   [N];        // Gated row bytes
    sa_pkg::act_t          act_h    [N][N+1];   // Horizontal links, col 0 is the skewed edge
    sa_pkg::psum_t         psum_v   [N+1][N];   // Vertical links, row 0 is the zero edge
    sa_pkg::psum_t         psum_out [N];        // Deskewed column sums
    sa_pkg::psum_t [N-1:0] psum_q;
    logic [LAT-1:0]        valid_q;

    // Input skew, row k waits k cycles
    for (genvar k = 0; k < N; k++) begin : g_skew
        assign act_in[k] = act_row_i.valid ? act_row_i.act[k] : '0;   // Zero bubbles
        if (k == 0) begin : g_pass
            assign act_h[k][0] = act_in[k];
        end else begin : g_dly
            sa_pkg::act_t [k-1:0] sh_q;
            always_ff @(posedge clk) begin
                sh_q[0] <= act_in[k];
                for (int d = 1; d < k; d++) begin
                    sh_q[d] <= sh_q[d-1];
                end
            end
            assign act_h[k][0] = sh_q[k-1];
        end
    end

    // PE grid
    for (genvar k = 0; k < N; k++) begin : g_row
        for (genvar j = 0; j < N; j++) begin : g_col
            sa_pe u_pe (
                .clk       (clk),
                .rst_n_i   (rst_n_i),
                .wt_load_i (wt_wr_i.we && (wt_wr_i.row == sa_pkg::idx_t'(k))),
                .wt_i      (wt_wr_i.wt[j]),
                .act_i     (act_h[k][j]),
                .act_o     (act_h[k][j+1]),
                .psum_i    (psum_v[k][j]),
                .psum_o    (psum_v[k+1][j])
            );
        end
    end

    // Output deskew, column j waits N-1-j cycles
    for (genvar j = 0; j < N; j++) begin : g_deskew
        localparam int D = N - 1 - j;
        assign psum_v[0][j] = '0;                   // Top edge starts from zero
        if (D == 0) begin : g_pass
            assign psum_out[j] = psum_v[N][j];
        end else begin : g_dly
            sa_pkg::psum_t [D-1:0] sh_q;
            always_ff @(posedge clk) begin
                sh_q[0] <= psum_v[N][j];
                for (int d = 1; d < D; d++) begin
                    sh_q[d] <= sh_q[d-1];
                end
            end
            assign psum_out[j] = sh_q[D-1];
        end
    end

    // Final stage brings total to LAT
    always_ff @(posedge clk) begin
        for (int j = 0; j < N; j++) begin
            psum_q[j] <= psum_out[j];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[LAT-2:0], act_row_i.valid};
        end
    end

    assign psum_row_o.valid = valid_q[LAT-1];
    assign psum_row_o.psum  = psum_q;

endmodule

// ==== hw/sa_ctrl.sv ====
`timescale 1ns/1ps
`include "sa_settings.svh"

module sa_ctrl (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  sa_pkg::wb_req_s                 wb_req_i,
    output sa_pkg::wb_rsp_s                 wb_rsp_o,
    output sa_pkg::act_row_s                act_row_o,
    output sa_pkg::wt_wr_s                  wt_wr_o,
    output sa_pkg::col_vec_t                rden_o,     // Pop strobe, one column
    input  sa_pkg::psum_t [`SA_PE_SIZE-1:0] head_i,
    input  sa_pkg::col_vec_t                full_i,
    input  sa_pkg::col_vec_t                empty_i
);

    localparam int N     = `SA_PE_SIZE;
    localparam int LAT   = `SA_LATENCY;
    localparam int CNT_W = $clog2(LAT + 2);

    sa_pkg::ctrl_state_e  state_q;
    sa_pkg::ctrl_state_e  state_d;
    logic                 req;
    logic                 is_stat;
    logic                 is_act;
    logic                 is_wt;
    logic                 is_res;
    logic                 needs_drain;                  // Wt write or result read
    logic                 busy;
    logic                 go;                           // Request completes now
    sa_pkg::idx_t         idx;
    sa_pkg::wb_dat_t      status;
    sa_pkg::wb_dat_t      rd_data;
    logic                 act_valid_q;
    logic                 wt_we_q;
    sa_pkg::idx_t         wt_row_q;
    sa_pkg::act_t [N-1:0] bytes_q;                      // Shared by act and wt paths
    sa_pkg::wb_dat_t      rsp_dat_q;
    logic [CNT_W-1:0]     inflight_q;
    logic [LAT-1:0]       issue_q;                      // Issue flags, one per cycle

    // Address decode
    assign req     = wb_req_i.cyc && wb_req_i.stb;
    assign is_stat = wb_req_i.adr == sa_pkg::wb_adr_t'(`SA_REG_STATUS);
    assign is_act  = wb_req_i.adr == sa_pkg::wb_adr_t'(`SA_REG_ACT);
    assign is_wt   = (int'(wb_req_i.adr) >= `SA_REG_WT_BASE) &&
                     (int'(wb_req_i.adr) <  `SA_REG_WT_BASE + N);
    assign is_res  = (int'(wb_req_i.adr) >= `SA_REG_RES_BASE) &&
                     (int'(wb_req_i.adr) <  `SA_REG_RES_BASE + N);
    assign idx     = is_wt ? sa_pkg::idx_t'(int'(wb_req_i.adr) - `SA_REG_WT_BASE)
                           : sa_pkg::idx_t'(int'(wb_req_i.adr) - `SA_REG_RES_BASE);

    assign needs_drain = wb_req_i.we ? is_wt : is_res;
    assign busy        = inflight_q != '0;

    always_comb begin
        status            = '0;
        status[0]         = busy;
        status[4 +: N]    = full_i;
        status[8 +: N]    = empty_i;
    end

    // Read mux, zero for write-only or empty column
    always_comb begin
        rd_data = '0;
        if (is_stat) begin
            rd_data = status;
        end else if (is_res && !empty_i[idx]) begin
            rd_data = sa_pkg::wb_dat_t'(head_i[idx]);
        end
    end

    always_comb begin
        state_d = state_q;
        go      = 1'b0;
        case (state_q)
            sa_pkg::CTRL_IDLE: begin
                if (req && needs_drain && busy) begin
                    state_d = sa_pkg::CTRL_DRAIN;       // Wait out rows in flight
                end else if (req) begin
                    go      = 1'b1;
                    state_d = sa_pkg::CTRL_ACK;
                end
            end
            sa_pkg::CTRL_ACK:   state_d = sa_pkg::CTRL_IDLE;    // Never two acks in a row
            sa_pkg::CTRL_DRAIN: begin
                if (!req) begin
                    state_d = sa_pkg::CTRL_IDLE;        // Host abandoned the cycle
                end else if (!busy) begin
                    go      = 1'b1;
                    state_d = sa_pkg::CTRL_ACK;
                end
            end
            default:            state_d = sa_pkg::CTRL_IDLE;
        endcase
    end

    // Pop lands on the same edge as ack rise
    always_comb begin
        rden_o = '0;
        if (go && !wb_req_i.we && is_res && !empty_i[idx]) rden_o[idx] = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q     <= sa_pkg::CTRL_IDLE;
            act_valid_q <= 1'b0;
            wt_we_q     <= 1'b0;
            issue_q     <= '0;
            inflight_q  <= '0;
        end else begin
            state_q     <= state_d;
            act_valid_q <= go && wb_req_i.we && is_act;
            wt_we_q     <= go && wb_req_i.we && is_wt;
            issue_q     <= {issue_q[LAT-2:0], act_valid_q};
            // Drops the cycle after the row's psum write
            inflight_q  <= inflight_q + CNT_W'(act_valid_q) - CNT_W'(issue_q[LAT-1]);
        end
    end

    always_ff @(posedge clk) begin
        if (go) begin
            rsp_dat_q <= wb_req_i.we ? '0 : rd_data;
            wt_row_q  <= idx;
            for (int k = 0; k < N; k++) begin
                bytes_q[k] <= sa_pkg::act_t'(wb_req_i.dat[`SA_ACT_W*k +: `SA_ACT_W]);
            end
        end
    end

    assign wb_rsp_o.ack    = state_q == sa_pkg::CTRL_ACK;
    assign wb_rsp_o.dat    = rsp_dat_q;
    assign act_row_o.valid = act_valid_q;               // Pulses with ack
    assign act_row_o.act   = bytes_q;
    assign wt_wr_o.we      = wt_we_q;
    assign wt_wr_o.row     = wt_row_q;
    assign wt_wr_o.wt      = bytes_q;

endmodule

// ==== hw/sa_pe.sv ====
`timescale 1ns/1ps

module sa_pe (
    input  logic          clk,
    input  logic          rst_n_i,
    input  logic          wt_load_i,    // Latch new stationary weight
    input  sa_pkg::act_t  wt_i,
    input  sa_pkg::act_t  act_i,        // From the left
    output sa_pkg::act_t  act_o,        // To the right
    input  sa_pkg::psum_t psum_i,       // From above
    output sa_pkg::psum_t psum_o        // Downward
);

    sa_pkg::act_t  wt_q;
    sa_pkg::prod_t prod;

    // Signed 8x8, sign-extended before the add
    assign prod = act_i * wt_q;

    // Stationary weight
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wt_q <= '0;
        end else if (wt_load_i) begin
            wt_q <= wt_i;
        end
    end

    // One stage for both directions
    always_ff @(posedge clk) begin
        act_o  <= act_i;
        psum_o <= psum_i + sa_pkg::psum_t'(prod);   // Wraps mod 2^32
    end

endmodule

// ==== hw/sa_pkg.sv ====
`include "sa_settings.svh"

package sa_pkg;

    typedef logic signed [`SA_ACT_W-1:0]    act_t;      // Activation or weight byte
    typedef logic signed [2*`SA_ACT_W-1:0]  prod_t;     // Full byte product
    typedef logic signed [`SA_PSUM_W-1:0]   psum_t;     // Wraps mod 2^32
    typedef logic [`SA_ADR_W-1:0]           wb_adr_t;
    typedef logic [31:0]                    wb_dat_t;
    typedef logic [`SA_PE_SIZE-1:0]         col_vec_t;  // One bit per column
    typedef logic [$clog2(`SA_PE_SIZE)-1:0] idx_t;      // Row or column index

    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        wb_adr_t    adr;
        wb_dat_t    dat;
        logic [3:0] sel;                                // Byte lanes, not decoded
    } wb_req_s;

    typedef struct packed {
        logic    ack;
        wb_dat_t dat;
    } wb_rsp_s;

    typedef struct packed {
        logic                    valid;
        act_t [`SA_PE_SIZE-1:0]  act;                   // Entry k feeds array row k
    } act_row_s;

    typedef struct packed {
        logic                    we;
        idx_t                    row;
        act_t [`SA_PE_SIZE-1:0]  wt;                    // Entry j for column j
    } wt_wr_s;

    typedef struct packed {
        logic                    valid;
        psum_t [`SA_PE_SIZE-1:0] psum;
    } psum_row_s;

    // Bus sequencer
    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_ACK,                                       // Single ack cycle
        CTRL_DRAIN                                      // Held until pipeline empty
    } ctrl_state_e;

endpackage

// ==== hw/sa_top.sv ====
`timescale 1ns/1ps
`include "sa_settings.svh"

module sa_top (
    input  logic            clk,
    input  logic            rst_n_i,
    input  sa_pkg::wb_req_s wb_req_i,
    output sa_pkg::wb_rsp_s wb_rsp_o
);

    sa_pkg::act_row_s                act_row;   // Ctrl to array
    sa_pkg::wt_wr_s                  wt_wr;
    sa_pkg::psum_row_s               psum_row;  // Array to accumulator
    sa_pkg::col_vec_t                rden;
    sa_pkg::col_vec_t                full;
    sa_pkg::col_vec_t                empty;
    sa_pkg::psum_t [`SA_PE_SIZE-1:0] head;

    // Bus decode and sequencing
    sa_ctrl u_ctrl (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .wb_req_i   (wb_req_i),
        .wb_rsp_o   (wb_rsp_o),
        .act_row_o  (act_row),
        .wt_wr_o    (wt_wr),
        .rden_o     (rden),
        .head_i     (head),
        .full_i     (full),
        .empty_i    (empty)
    );

    sa_array u_array (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .act_row_i  (act_row),
        .wt_wr_i    (wt_wr),
        .psum_row_o (psum_row)
    );

    // Per-column accumulation FIFOs
    sa_acc u_acc (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .psum_row_i (psum_row),
        .rden_i     (rden),
        .head_o     (head),
        .full_o     (full),
        .empty_o    (empty)
    );

endmodule

// ==== include/sa_settings.svh ====
`ifndef SA_SETTINGS_SVH
`define SA_SETTINGS_SVH

// Array geometry
`define SA_PE_SIZE      4                   // PE rows and columns
`define SA_ACT_W        8                   // Activation and weight bits
`define SA_PSUM_W       32                  // Partial sum bits
`define SA_FIFO_DEPTH   4                   // Accumulator entries per column

`define SA_ADR_W        4                   // Wishbone word address bits

// Row in at the array edge to psum row at the accumulator
`define SA_LATENCY      (2 * `SA_PE_SIZE)

// Register map, word addresses
`define SA_REG_STATUS   0                   // busy, full, empty
`define SA_REG_ACT      1                   // One activation row per write
`define SA_REG_WT_BASE  4                   // Weight row k at base + k
`define SA_REG_RES_BASE 8                   // Result column j at base + j

`endif

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f sim.f \
    --top-module sa_tb \
    --Mdir obj_dir \
    -o sa_tb_sim

./obj_dir/sa_tb_sim

// ==== sim.f ====
+incdir+include
hw/sa_pkg.sv
hw/sa_pe.sv
hw/sa_array.sv
hw/sa_acc_fifo.sv
hw/sa_acc.sv
hw/sa_ctrl.sv
hw/sa_top.sv
testbench/sa_assert.sv
testbench/sa_tb.sv

// ==== testbench/sa_assert.sv ====
`timescale 1ns/1ps

module sa_assert (
    input logic               clk,
    input logic               rst_n_i,
    input sa_pkg::wb_req_s    wb_req_i,
    input sa_pkg::wb_rsp_s    wb_rsp_i,     // DUT response
    input sa_pkg::act_row_s   act_row_i,
    input sa_pkg::wt_wr_s     wt_wr_i,
    input sa_pkg::psum_row_s  psum_row_i,   // Array to accumulator
    input sa_pkg::col_vec_t   rden_i        // Host pop strobe
);

    // Ack only inside an active bus cycle
    ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n_i)
        wb_rsp_i.ack |-> (wb_req_i.cyc && wb_req_i.stb))
        else $error("Ack raised outside an active bus cycle");

    ack_single: assert property (@(posedge clk) disable iff (!rst_n_i)
        wb_rsp_i.ack |=> !wb_rsp_i.ack)     // One cycle wide
        else $error("Ack held high for two cycles");

    // Drain keeps host pops off accumulating writes
    pop_vs_acc: assert property (@(posedge clk) disable iff (!rst_n_i)
        !((|rden_i) && psum_row_i.valid))
        else $error("Host pop collided with a psum row write");

    act_vs_wt: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(act_row_i.valid && wt_wr_i.we))
        else $error("Activation row and weight write issued together");

endmodule

bind sa_top sa_assert u_assert (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .wb_req_i   (wb_req_i),
    .wb_rsp_i   (wb_rsp_o),
    .act_row_i  (act_row),
    .wt_wr_i    (wt_wr),
    .psum_row_i (psum_row),
    .rden_i     (rden)
);

// ==== testbench/sa_tb.sv ====
`timescale 1ns/1ps
`include "sa_settings.svh"

module sa_tb;

    localparam int N           = `SA_PE_SIZE;
    localparam int DEPTH       = `SA_FIFO_DEPTH;
    localparam int LAT         = `SA_LATENCY;
    localparam int NUM_OPS     = 130;                       // Upper bound over all tests
    localparam int WDOG_CYCLES = NUM_OPS * 4 * LAT + 500;   // Plus margin

    logic            clk;
    logic            rst_n;
    sa_pkg::wb_req_s req;
    sa_pkg::wb_rsp_s rsp;

    sa_pkg::act_t    wt_m  [N][N];      // Model weights by row and column
    logic [31:0]     col_q [N][$];      // Model accumulator per column

    sa_top DUT (
        .clk      (clk),
        .rst_n_i  (rst_n),
        .wb_req_i (req),
        .wb_rsp_o (rsp)
    );

    always #4 clk = ~clk;               // 8 ns period

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp) else begin
            $display("FAILED %s: expected 0x%08h, actual 0x%08h", name, exp, got);
            $display("Result: FAILED");
            $fatal(1, "Check %s failed", name);
        end
    endtask

    // Called and returns on a falling edge
    task automatic bus_cycle(input logic we, input int adr, input logic [31:0] wdat,
                             output logic [31:0] rdat);
        req.cyc = 1'b1;
        req.stb = 1'b1;
        req.we  = we;
        req.adr = sa_pkg::wb_adr_t'(adr);
        req.dat = wdat;
        req.sel = 4'hf;
        do @(negedge clk); while (!rsp.ack);   // No fixed latency as drains may stall
        rdat = rsp.dat;
        @(negedge clk);                         // Hold through the ack edge
        req.cyc = 1'b0;
        req.stb = 1'b0;
        req.we  = 1'b0;
    endtask

    task automatic bus_write(input int adr, input logic [31:0] wdat);
        logic [31:0] unused;
        bus_cycle(1'b1, adr, wdat, unused);
    endtask

    task automatic bus_read(input int adr, output logic [31:0] rdat);
        bus_cycle(1'b0, adr, '0, rdat);
    endtask

    function automatic sa_pkg::act_t pick_byte(input bit extreme);
        if (extreme) return ($urandom() & 1) ? 8'h80 : 8'h7f;   // Most negative or positive
        return 8'($urandom());
    endfunction

    task automatic load_weights(input bit extreme);
        logic [31:0] word;
        for (int k = 0; k < N; k++) begin
            word = '0;
            for (int j = 0; j < N; j++) begin
                wt_m[k][j]      = pick_byte(extreme);
                word[8*j +: 8] = wt_m[k][j];                // Byte j to column j
            end
            bus_write(`SA_REG_WT_BASE + k, word);
        end
    endtask

    // Dot product per column then preload or fold into oldest
    task automatic send_act(input bit extreme);
        logic [31:0]  word;
        sa_pkg::act_t a;
        logic [31:0]  sum;
        logic [31:0]  head;
        for (int k = 0; k < N; k++) word[8*k +: 8] = pick_byte(extreme);
        for (int j = 0; j < N; j++) begin
            sum = '0;
            for (int k = 0; k < N; k++) begin
                a   = word[8*k +: 8];
                sum = sum + 32'(int'(a) * int'(wt_m[k][j]));   // Mod 2^32
            end
            if (col_q[j].size() < DEPTH) begin
                col_q[j].push_back(sum);
            end else begin
                head = col_q[j].pop_front();
                col_q[j].push_back(head + sum);
            end
        end
        bus_write(`SA_REG_ACT, word);
    endtask

    task automatic check_result(input string name, input int col);
        logic [31:0] exp;
        logic [31:0] got;
        exp = (col_q[col].size() == 0) ? 32'h0 : col_q[col].pop_front();   // Empty reads 0
        bus_read(`SA_REG_RES_BASE + col, got);
        check_val($sformatf("%s col%0d", name, col), exp, got);
    endtask

    task automatic drain_all(input string name);
        for (int j = 0; j < N; j++) begin
            for (int r = 0; r < DEPTH; r++) check_result(name, j);
        end
    endtask

    // Only valid with the pipeline empty
    task automatic check_status(input string name);
        logic [31:0] exp;
        logic [31:0] got;
        exp = '0;
        for (int j = 0; j < N; j++) begin
            exp[4 + j] = col_q[j].size() == DEPTH;
            exp[8 + j] = col_q[j].size() == 0;
        end
        bus_read(`SA_REG_STATUS, got);
        check_val(name, exp, got);
    endtask

    // Watchdog
    initial begin
        repeat (WDOG_CYCLES) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", WDOG_CYCLES);
        $display("Result: FAILED");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        logic [31:0] rdat;
        int          rows;
        void'($urandom(32'hbe24_33dd));
        clk = 1'b0;
        rst_n = 1'b0;
        req = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Idle after reset
        check_status("reset status");
        for (int j = 0; j < N; j++) check_result("reset read", j);

        // Preload of one tile
        load_weights(1'b0);
        for (int r = 0; r < DEPTH; r++) send_act(1'b0);
        drain_all("preload");
        check_status("preload status");

        // Three tiles folded together with the middle one at extremes
        for (int t = 0; t < 3; t++) begin
            load_weights(t == 1);
            for (int r = 0; r < DEPTH; r++) send_act(t == 1);
        end
        drain_all("tiles");
        check_status("tiles status");

        // Back-pressure behind rows in flight
        load_weights(1'b0);
        send_act(1'b0);
        bus_read(`SA_REG_STATUS, rdat);
        check_val("stall busy", 32'h1, {31'h0, rdat[0]});
        check_result("stall read", 0);          // Column stays empty until the row lands
        send_act(1'b0);
        load_weights(1'b0);                     // Stalls until both rows land
        send_act(1'b0);
        send_act(1'b0);
        drain_all("stall");                     // First read stalls too
        check_status("stall status");

        // Partial tile with trailing reads of 0
        rows = 1 + int'($urandom() % (DEPTH - 1));
        load_weights(1'b0);
        for (int r = 0; r < rows; r++) send_act(1'b0);
        check_result("partial first", 0);
        check_status("partial mid status");
        for (int r = 1; r < DEPTH; r++) check_result("partial", 0);
        for (int j = 1; j < N; j++) begin
            for (int r = 0; r < DEPTH; r++) check_result("partial", j);
        end
        check_status("partial status");

        $display("Result: PASSED");
        $finish;
    end

endmodule
